// ==== logic/block_encoder.sv ====
// 64b/66b block encoder
module block_encoder
(
    input  wire                                 i_clock,
    input  wire                                 i_reset,
    input  wire                                 i_valid,
    input  wire  [pcs_tx_pkg::NB_PAYLOAD-1:0]   i_data,
    input  wire  [pcs_tx_pkg::NB_CTRL-1:0]      i_ctrl,
    output logic                                o_valid,
    output logic [pcs_tx_pkg::NB_BLOCK-1:0]     o_block
);

    localparam int NB_BLOCK   = pcs_tx_pkg::NB_BLOCK;
    localparam int NB_PAYLOAD = pcs_tx_pkg::NB_PAYLOAD;
    localparam int NB_CTRL    = pcs_tx_pkg::NB_CTRL;

    logic                  is_data;
    logic                  is_idle;
    logic [6:0]            ctrl_code;
    logic [NB_PAYLOAD-1:0] ctrl_payload;
    logic [NB_BLOCK-1:0]   block_next;

    // classify the transfer
    always_comb
    begin
        is_data = (i_ctrl == '0);
        // idle needs every flag set and every byte an idle character
        is_idle = (i_ctrl == '1)
                  && (i_data == {NB_CTRL{pcs_tx_pkg::IDLE_CHAR}});
    end

    // control payload: type byte then eight 7-bit codes
    always_comb
    begin
        if (is_idle)
        begin
            ctrl_code = pcs_tx_pkg::CODE_IDLE;
        end
        else
        begin
            ctrl_code = pcs_tx_pkg::CODE_ERROR;
        end
        ctrl_payload = {{NB_CTRL{ctrl_code}}, pcs_tx_pkg::BLOCK_TYPE_CTRL};
    end

    always_comb
    begin
        if (is_data)
        begin
            block_next = {i_data, pcs_tx_pkg::SH_DATA};
        end
        else
        begin
            block_next = {ctrl_payload, pcs_tx_pkg::SH_CTRL};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    // payload register, loaded on each strobe
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_block <= block_next;
        end
    end

endmodule

// ==== logic/block_scrambler.sv ====
// self-synchronizing payload scrambler
module block_scrambler
#(
    parameter logic [pcs_tx_pkg::NB_SCRAMBLER-1:0] SCRAMBLER_SEED =
        {pcs_tx_pkg::NB_SCRAMBLER{1'b1}}
)
(
    input  wire                                 i_clock,
    input  wire                                 i_reset,
    input  wire                                 i_valid,
    input  wire                                 i_bypass,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1:0]     i_block,
    output logic                                o_valid,
    output logic [pcs_tx_pkg::NB_BLOCK-1:0]     o_block
);

    localparam int NB_PAYLOAD   = pcs_tx_pkg::NB_PAYLOAD;
    localparam int NB_SCRAMBLER = pcs_tx_pkg::NB_SCRAMBLER;
    // x^58 + x^39 + 1
    localparam int TAP_NEAR     = 39;

    // history, bit 0 is the most recent scrambled bit
    logic [NB_SCRAMBLER-1:0] state;
    logic [NB_SCRAMBLER-1:0] state_next;
    logic [NB_PAYLOAD-1:0]   scr_payload;

    // serial recurrence unrolled over the payload, bit 0 first
    always_comb
    begin
        logic scr_bit;
        state_next = state;
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            scr_bit = i_block[i+2] ^ state_next[TAP_NEAR-1]
                      ^ state_next[NB_SCRAMBLER-1];
            scr_payload[i] = scr_bit;
            state_next = {state_next[NB_SCRAMBLER-2:0], scr_bit};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
            state   <= SCRAMBLER_SEED;
        end
        else
        begin
            o_valid <= i_valid;
            // history holds still while bypassed
            if (i_valid && !i_bypass)
            begin
                state <= state_next;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_block <= i_bypass ? i_block : {scr_payload, i_block[1:0]};
        end
    end

endmodule

// ==== logic/lane_distributor.sv ====
// round-robin lane distributor
module lane_distributor
#(
    parameter int N_LANES = 4
)
(
    input  wire                                 i_clock,
    input  wire                                 i_reset,
    input  wire                                 i_valid,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1:0]     i_block,
    output logic [N_LANES-1:0]                  o_valid,
    output logic [pcs_tx_pkg::NB_BLOCK-1:0]     o_block
);

    localparam int PTR_W = $clog2(N_LANES);

    logic [PTR_W-1:0] lane_ptr;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            lane_ptr <= '0;
            o_valid  <= '0;
        end
        else if (i_valid)
        begin
            // one-hot strobe for the current lane
            o_valid <= N_LANES'(1) << lane_ptr;
            if (lane_ptr == PTR_W'(N_LANES-1))
            begin
                lane_ptr <= '0;
            end
            else
            begin
                lane_ptr <= lane_ptr + PTR_W'(1);
            end
        end
        else
        begin
            o_valid <= '0;
        end
    end

    // one block register shared by all lanes
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_block <= i_block;
        end
    end

endmodule

// ==== logic/lane_marker_inserter.sv ====
// per-lane alignment marker insertion
module lane_marker_inserter
#(
    parameter int LANE_ID   = 0,
    parameter int AM_PERIOD = 8
)
(
    input  wire                                 i_clock,
    input  wire                                 i_reset,
    input  wire                                 i_valid,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1:0]     i_block,
    output logic                                o_valid,
    output logic [pcs_tx_pkg::NB_BLOCK-1:0]     o_block
);

    localparam int NB_BLOCK = pcs_tx_pkg::NB_BLOCK;
    localparam int NB_BIP   = pcs_tx_pkg::NB_BIP;
    localparam int CNT_W    = $clog2(AM_PERIOD + 1);

    localparam logic [23:0] AM_BYTES = pcs_tx_pkg::MARKER_TABLE[LANE_ID];
    localparam logic [7:0]  AM_M0    = AM_BYTES[23:16];
    localparam logic [7:0]  AM_M1    = AM_BYTES[15:8];
    localparam logic [7:0]  AM_M2    = AM_BYTES[7:0];

    // two-entry queue
    logic [NB_BLOCK-1:0] q_mem [2];
    logic                wr_ptr;
    logic                rd_ptr;
    logic [1:0]          q_count;

    logic [CNT_W-1:0]    data_count;
    logic [NB_BIP-1:0]   bip;

    logic                marker_due;
    logic                emit;
    logic                push;
    logic                pop;
    logic [NB_BLOCK-1:0] marker_block;
    logic [NB_BLOCK-1:0] emit_block;

    // even parity per bit position modulo 8
    function automatic logic [NB_BIP-1:0] block_bip
    (
        input logic [NB_BLOCK-1:0] blk
    );
        logic [NB_BIP-1:0] acc;
        acc = '0;
        for (int p = 0; p < NB_BLOCK; p++)
        begin
            acc[p % NB_BIP] ^= blk[p];
        end
        return acc;
    endfunction

    always_comb
    begin
        marker_due   = (data_count == CNT_W'(AM_PERIOD));
        marker_block = {~bip, ~AM_M2, ~AM_M1, ~AM_M0,
                        bip, AM_M2, AM_M1, AM_M0, pcs_tx_pkg::SH_CTRL};
        emit = marker_due || (q_count != 2'd0) || i_valid;
        pop  = !marker_due && (q_count != 2'd0);
        // the incoming block skips the queue when nothing is ahead of it
        push = i_valid && (marker_due || (q_count != 2'd0));
        if (marker_due)
        begin
            emit_block = marker_block;
        end
        else if (q_count != 2'd0)
        begin
            emit_block = q_mem[rd_ptr];
        end
        else
        begin
            emit_block = i_block;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid    <= 1'b0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            q_count    <= 2'd0;
            data_count <= '0;
            bip        <= '0;
        end
        else
        begin
            o_valid <= emit;
            if (push)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop)
            begin
                rd_ptr <= ~rd_ptr;
            end
            q_count <= q_count + {1'b0, push} - {1'b0, pop};
            if (marker_due)
            begin
                // next parity starts with the marker itself
                data_count <= '0;
                bip        <= block_bip(marker_block);
            end
            else if (emit)
            begin
                data_count <= data_count + CNT_W'(1);
                bip        <= bip ^ block_bip(emit_block);
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (push)
        begin
            q_mem[wr_ptr] <= i_block;
        end
        if (emit)
        begin
            o_block <= emit_block;
        end
    end

endmodule

// ==== logic/lane_word_packer.sv ====
// multi-lane word packer
module lane_word_packer
#(
    parameter int N_LANES = 4
)
(
    input  wire                                         i_clock,
    input  wire                                         i_reset,
    input  wire  [N_LANES-1:0]                          i_valid,
    input  wire  [N_LANES*pcs_tx_pkg::NB_BLOCK-1:0]     i_block,
    output logic                                        o_valid,
    output logic [N_LANES*pcs_tx_pkg::NB_BLOCK-1:0]     o_word
);

    localparam int NB_BLOCK = pcs_tx_pkg::NB_BLOCK;

    logic [N_LANES-1:0]          full;
    logic [N_LANES-1:0]          spare;
    logic [NB_BLOCK-1:0]         hold_block [N_LANES];
    logic [NB_BLOCK-1:0]         spare_block [N_LANES];
    logic [N_LANES*NB_BLOCK-1:0] word_next;
    logic                        fire;

    // word completes when every lane is held or arriving now
    always_comb
    begin
        fire = &(full | i_valid);
        for (int k = 0; k < N_LANES; k++)
        begin
            word_next[k*NB_BLOCK +: NB_BLOCK] =
                full[k] ? hold_block[k] : i_block[k*NB_BLOCK +: NB_BLOCK];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            full    <= '0;
            spare   <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= fire;
            for (int k = 0; k < N_LANES; k++)
            begin
                // a held lane may already deliver its next block
                if (fire)
                begin
                    full[k]  <= spare[k] | (full[k] & i_valid[k]);
                    spare[k] <= spare[k] & i_valid[k];
                end
                else if (i_valid[k])
                begin
                    // a marker can follow a held block before the word is complete
                    full[k]  <= 1'b1;
                    spare[k] <= full[k];
                end
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        for (int k = 0; k < N_LANES; k++)
        begin
            if (fire && spare[k])
            begin
                hold_block[k] <= spare_block[k];
            end
            else if (i_valid[k] && (fire == full[k]))
            begin
                hold_block[k] <= i_block[k*NB_BLOCK +: NB_BLOCK];
            end
            if (i_valid[k] && (fire ? spare[k] : full[k]))
            begin
                spare_block[k] <= i_block[k*NB_BLOCK +: NB_BLOCK];
            end
        end
        if (fire)
        begin
            o_word <= word_next;
        end
    end

endmodule

// ==== logic/pcs_tx_pkg.sv ====
// 64b/66b transmit definitions
package pcs_tx_pkg;

    // block geometry
    localparam int NB_BLOCK     = 66;
    localparam int NB_PAYLOAD   = 64;
    localparam int NB_CTRL      = 8;
    localparam int NB_SCRAMBLER = 58;
    localparam int NB_BIP       = 8;

    // sync headers, sent in block bits 1..0
    localparam logic [1:0] SH_DATA = 2'b01;
    localparam logic [1:0] SH_CTRL = 2'b10;

    // control block type byte and raw idle character
    localparam logic [7:0] BLOCK_TYPE_CTRL = 8'h1E;
    localparam logic [7:0] IDLE_CHAR       = 8'h07;

    // 7-bit control codes in the control block payload
    localparam logic [6:0] CODE_IDLE  = 7'h00;
    localparam logic [6:0] CODE_ERROR = 7'h1E;

    localparam int MAX_LANES = 8;

    // per-lane marker bytes packed as {M0, M1, M2}
    // M0 in bits 23..16, M2 in bits 7..0
    localparam logic [23:0] MARKER_TABLE [0:MAX_LANES-1] = '{
        24'h907647,
        24'hF0C4E6,
        24'hC5659B,
        24'hA2793D,
        24'hF50709,
        24'hDD14C2,
        24'h9A4A26,
        24'h7B4566
    };

endpackage

// ==== logic/pcs_tx_top.sv ====
// multi-lane 64b/66b transmit top level
module pcs_tx_top
#(
    parameter int N_LANES   = 4,
    parameter int AM_PERIOD = 8,
    parameter logic [pcs_tx_pkg::NB_SCRAMBLER-1:0] SCRAMBLER_SEED =
        {pcs_tx_pkg::NB_SCRAMBLER{1'b1}}
)
(
    input  wire                                         i_clock,
    input  wire                                         i_reset,
    input  wire                                         i_valid,
    input  wire  [pcs_tx_pkg::NB_PAYLOAD-1:0]           i_data,
    input  wire  [pcs_tx_pkg::NB_CTRL-1:0]              i_ctrl,
    input  wire                                         i_scrambler_bypass,
    output logic                                        o_valid,
    output logic [N_LANES*pcs_tx_pkg::NB_BLOCK-1:0]     o_word
);

    localparam int NB_BLOCK = pcs_tx_pkg::NB_BLOCK;

    logic                        enc_valid;
    logic [NB_BLOCK-1:0]         enc_block;
    logic                        scr_valid;
    logic [NB_BLOCK-1:0]         scr_block;
    logic [N_LANES-1:0]          dist_valid;
    logic [NB_BLOCK-1:0]         dist_block;
    logic [N_LANES-1:0]          lane_valid;
    logic [N_LANES*NB_BLOCK-1:0] lane_block;

    block_encoder u_encoder
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_data  (i_data),
        .i_ctrl  (i_ctrl),
        .o_valid (enc_valid),
        .o_block (enc_block)
    );

    block_scrambler
    #(
        .SCRAMBLER_SEED (SCRAMBLER_SEED)
    )
    u_scrambler
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (enc_valid),
        .i_bypass (i_scrambler_bypass),
        .i_block  (enc_block),
        .o_valid  (scr_valid),
        .o_block  (scr_block)
    );

    lane_distributor
    #(
        .N_LANES (N_LANES)
    )
    u_distributor
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (scr_valid),
        .i_block (scr_block),
        .o_valid (dist_valid),
        .o_block (dist_block)
    );

    // lane k takes the shared block on its own strobe
    for (genvar k = 0; k < N_LANES; k++)
    begin : g_lane
        lane_marker_inserter
        #(
            .LANE_ID   (k),
            .AM_PERIOD (AM_PERIOD)
        )
        u_marker
        (
            .i_clock (i_clock),
            .i_reset (i_reset),
            .i_valid (dist_valid[k]),
            .i_block (dist_block),
            .o_valid (lane_valid[k]),
            .o_block (lane_block[k*NB_BLOCK +: NB_BLOCK])
        );
    end

    lane_word_packer
    #(
        .N_LANES (N_LANES)
    )
    u_packer
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (lane_valid),
        .i_block (lane_block),
        .o_valid (o_valid),
        .o_word  (o_word)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the 64b/66b transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -f vlog.f --top-module pcs_tx_tb -o pcs_tx_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/pcs_tx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1

// ==== verification/pcs_tx_model.svh ====
// 64b/66b transmit reference model
`ifndef PCS_TX_MODEL_SVH
`define PCS_TX_MODEL_SVH

// coded block for one transfer of eight bytes and eight flags
function automatic logic [pcs_tx_pkg::NB_BLOCK-1:0] encode_transfer
(
    input logic [63:0] data,
    input logic [7:0]  ctrl
);
    logic [63:0] payload;
    logic [6:0]  code;
    if (ctrl == 8'h00)
    begin
        return {data, pcs_tx_pkg::SH_DATA};
    end
    code = pcs_tx_pkg::CODE_ERROR;
    if ((ctrl == 8'hFF) && (data == {8{pcs_tx_pkg::IDLE_CHAR}}))
    begin
        code = pcs_tx_pkg::CODE_IDLE;
    end
    payload[7:0] = pcs_tx_pkg::BLOCK_TYPE_CTRL;
    for (int k = 0; k < 8; k++)
    begin
        payload[8+7*k +: 7] = code;
    end
    return {payload, pcs_tx_pkg::SH_CTRL};
endfunction

// state bit m is the scrambled bit m+1 positions back
function automatic logic [pcs_tx_pkg::NB_BLOCK-1:0] scramble_block
(
    input logic [pcs_tx_pkg::NB_BLOCK-1:0]     blk,
    inout logic [pcs_tx_pkg::NB_SCRAMBLER-1:0] state
);
    logic [121:0]                   seq;
    logic [pcs_tx_pkg::NB_BLOCK-1:0] out;
    // seq runs oldest to newest, history first
    for (int m = 0; m < 58; m++)
    begin
        seq[57-m] = state[m];
    end
    out = blk;
    for (int i = 0; i < 64; i++)
    begin
        seq[58+i] = blk[2+i] ^ seq[58+i-39] ^ seq[58+i-58];
        out[2+i]  = seq[58+i];
    end
    for (int m = 0; m < 58; m++)
    begin
        state[m] = seq[121-m];
    end
    return out;
endfunction

// fold one block into a running BIP-8
function automatic logic [7:0] bip_update
(
    input logic [7:0]                      bip,
    input logic [pcs_tx_pkg::NB_BLOCK-1:0] blk
);
    logic [7:0] acc;
    acc = bip;
    for (int p = 0; p < pcs_tx_pkg::NB_BLOCK; p++)
    begin
        acc[p % 8] = acc[p % 8] ^ blk[p];
    end
    return acc;
endfunction

function automatic logic [pcs_tx_pkg::NB_BLOCK-1:0] marker_block
(
    input int         lane,
    input logic [7:0] bip
);
    logic [23:0]                     m;
    logic [7:0]                      am [8];
    logic [pcs_tx_pkg::NB_BLOCK-1:0] blk;
    m = pcs_tx_pkg::MARKER_TABLE[lane];
    am[0] = m[23:16];
    am[1] = m[15:8];
    am[2] = m[7:0];
    am[3] = bip;
    // second half repeats the first half inverted
    for (int k = 0; k < 4; k++)
    begin
        am[4+k] = ~am[k];
    end
    blk[1:0] = pcs_tx_pkg::SH_CTRL;
    for (int k = 0; k < 8; k++)
    begin
        blk[2+8*k +: 8] = am[k];
    end
    return blk;
endfunction

`endif

// ==== verification/pcs_tx_tb.sv ====
// 64b/66b transmit testbench
module pcs_tx_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int N_LANES     = 4;
    localparam int AM_PERIOD   = 8;
    localparam int NB_BLOCK    = pcs_tx_pkg::NB_BLOCK;
    localparam int NB_WORD     = N_LANES * NB_BLOCK;
    localparam int DRAIN_LIMIT = 200;
    localparam logic [pcs_tx_pkg::NB_SCRAMBLER-1:0] SEED = '1;

    logic                i_clock;
    logic                i_reset;
    logic                i_valid;
    logic [63:0]         i_data;
    logic [7:0]          i_ctrl;
    logic                i_scrambler_bypass;
    logic                o_valid;
    logic [NB_WORD-1:0]  o_word;

    // reference model state
    logic [pcs_tx_pkg::NB_SCRAMBLER-1:0] scr_state;
    logic                bypass_model;
    int                  lane_ptr;
    int                  lane_cnt [N_LANES];
    logic [7:0]          lane_bip [N_LANES];
    logic [NB_BLOCK-1:0] lane_q [N_LANES][$];
    logic                lane_mk [N_LANES][$];
    logic [NB_WORD-1:0]  exp_words [$];
    logic                exp_marker [$];

    logic [31:0]         rng_state;
    int                  stim_errors;
    int                  cmp_errors;
    int                  words_checked;
    int                  markers_seen;
    int                  tests_run;
    int                  test_errors0;
    int                  test_words0;

    `include "pcs_tx_model.svh"

    pcs_tx_top
    #(
        .N_LANES   (N_LANES),
        .AM_PERIOD (AM_PERIOD)
    )
    dut0
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_valid            (i_valid),
        .i_data             (i_data),
        .i_ctrl             (i_ctrl),
        .i_scrambler_bypass (i_scrambler_bypass),
        .o_valid            (o_valid),
        .o_word             (o_word)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic void model_reset(input logic bypass);
        scr_state    = SEED;
        bypass_model = bypass;
        lane_ptr     = 0;
        for (int k = 0; k < N_LANES; k++)
        begin
            lane_cnt[k] = 0;
            lane_bip[k] = 8'h00;
            lane_q[k].delete();
            lane_mk[k].delete();
        end
        exp_words.delete();
        exp_marker.delete();
    endfunction

    function automatic bit lanes_ready();
        for (int k = 0; k < N_LANES; k++)
        begin
            if (lane_q[k].size() == 0)
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // deal one block to its lane, add markers, collect full words
    function automatic void queue_expected(input logic [NB_BLOCK-1:0] blk);
        int                  lane;
        logic [NB_BLOCK-1:0] am;
        logic [NB_WORD-1:0]  word;
        logic                is_mk;
        lane     = lane_ptr;
        lane_ptr = (lane_ptr + 1) % N_LANES;
        lane_q[lane].push_back(blk);
        lane_mk[lane].push_back(1'b0);
        lane_bip[lane] = bip_update(lane_bip[lane], blk);
        lane_cnt[lane]++;
        if (lane_cnt[lane] == AM_PERIOD)
        begin
            am = marker_block(lane, lane_bip[lane]);
            lane_q[lane].push_back(am);
            lane_mk[lane].push_back(1'b1);
            // next parity starts with this marker
            lane_bip[lane] = bip_update(8'h00, am);
            lane_cnt[lane] = 0;
        end
        while (lanes_ready())
        begin
            is_mk = 1'b1;
            for (int k = 0; k < N_LANES; k++)
            begin
                word[k*NB_BLOCK +: NB_BLOCK] = lane_q[k].pop_front();
                is_mk = is_mk & lane_mk[k].pop_front();
            end
            exp_words.push_back(word);
            exp_marker.push_back(is_mk);
        end
    endfunction

    function automatic void report_lanes(input logic [NB_WORD-1:0] exp_word);
        for (int k = 0; k < N_LANES; k++)
        begin
            if (o_word[k*NB_BLOCK +: NB_BLOCK] !== exp_word[k*NB_BLOCK +: NB_BLOCK])
            begin
                $display("error at %0t ns: lane %0d got %h, expected %h", $time, k,
                         o_word[k*NB_BLOCK +: NB_BLOCK], exp_word[k*NB_BLOCK +: NB_BLOCK]);
            end
        end
    endfunction

    task automatic apply_reset(input logic bypass);
        @(posedge i_clock);
        i_reset            <= 1'b1;
        i_valid            <= 1'b0;
        i_scrambler_bypass <= bypass;
        repeat (2) @(posedge i_clock);
        i_reset <= 1'b0;
        model_reset(bypass);
    endtask

    task automatic send_transfer
    (
        input logic [63:0] data,
        input logic [7:0]  ctrl,
        input logic [1:0]  gap
    );
        logic [NB_BLOCK-1:0] blk;
        @(posedge i_clock);
        i_valid <= 1'b1;
        i_data  <= data;
        i_ctrl  <= ctrl;
        blk = encode_transfer(data, ctrl);
        if (!bypass_model)
        begin
            blk = scramble_block(blk, scr_state);
        end
        queue_expected(blk);
        repeat (gap)
        begin
            @(posedge i_clock);
            i_valid <= 1'b0;
        end
    endtask

    // data only, or a mix of data, idle and error transfers
    task automatic send_random(input bit mixed, input bit gaps);
        logic [31:0] r;
        logic [63:0] data;
        logic [7:0]  ctrl;
        logic [1:0]  gap;
        r           = next_random();
        data[63:32] = next_random();
        data[31:0]  = next_random();
        ctrl        = 8'h00;
        gap         = gaps ? r[31:30] : 2'd0;
        if (mixed)
        begin
            case (r[29:28])
                2'd1:
                begin
                    ctrl = 8'hFF;
                    data = {8{pcs_tx_pkg::IDLE_CHAR}};
                end
                2'd2:    ctrl = r[23:16];
                2'd3:    ctrl = 8'hFF;
                default: ctrl = 8'h00;
            endcase
        end
        send_transfer(data, ctrl, gap);
    endtask

    task automatic start_test();
        test_errors0 = stim_errors + cmp_errors;
        test_words0  = words_checked;
    endtask

    task automatic drain_words();
        int wait_cycles;
        @(posedge i_clock);
        i_valid <= 1'b0;
        wait_cycles = 0;
        while ((exp_words.size() != 0) && (wait_cycles < DRAIN_LIMIT))
        begin
            @(negedge i_clock);
            wait_cycles++;
        end
        if (exp_words.size() != 0)
        begin
            $display("timed out after %0d cycles, %0d expected words never came out",
                     wait_cycles, exp_words.size());
            stim_errors++;
            exp_words.delete();
            exp_marker.delete();
        end
        // short quiet window to catch extra words
        repeat (4) @(negedge i_clock);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d words checked, %0d errors", tests_run, name,
                 words_checked - test_words0, stim_errors + cmp_errors - test_errors0);
    endtask

    task automatic check_markers(input int seen, input int expected);
        assert (seen == expected)
        else
        begin
            $display("error at %0t ns: %0d marker words seen, expected %0d",
                     $time, seen, expected);
            stim_errors++;
        end
    endtask

    always @(negedge i_clock)
    begin
        logic [NB_WORD-1:0] exp_word;
        logic               exp_is_mk;
        if (o_valid === 1'b1)
        begin
            if (exp_words.size() == 0)
            begin
                $display("an output word came out at %0t ns with no word expected", $time);
                cmp_errors++;
            end
            else
            begin
                exp_word  = exp_words.pop_front();
                exp_is_mk = exp_marker.pop_front();
                words_checked++;
                assert (o_word === exp_word)
                begin
                    if (exp_is_mk)
                    begin
                        markers_seen++;
                    end
                end
                else
                begin
                    cmp_errors++;
                    report_lanes(exp_word);
                end
            end
        end
    end

    initial
    begin
        int mk0;
        i_reset            = 1'b1;
        i_valid            = 1'b0;
        i_data             = 64'h0;
        i_ctrl             = 8'h00;
        i_scrambler_bypass = 1'b0;
        rng_state          = 32'd65090;
        stim_errors        = 0;
        cmp_errors         = 0;
        words_checked      = 0;
        markers_seen       = 0;
        tests_run          = 0;
        model_reset(1'b0);

        // quiet after reset
        start_test();
        apply_reset(1'b0);
        repeat (16)
        begin
            @(negedge i_clock);
            assert (o_valid == 1'b0)
            else
            begin
                $display("error at %0t ns: o_valid high with no input strobes", $time);
                stim_errors++;
            end
        end
        end_test("reset quiet");

        start_test();
        apply_reset(1'b0);
        repeat (64) send_random(1'b0, 1'b0);
        drain_words();
        end_test("random data");

        start_test();
        apply_reset(1'b0);
        repeat (64) send_random(1'b1, 1'b0);
        drain_words();
        end_test("idle and error blocks");

        // bypassed run, then scrambling must resume from the seed
        start_test();
        apply_reset(1'b1);
        repeat (32) send_random(1'b1, 1'b0);
        drain_words();
        @(posedge i_clock);
        i_scrambler_bypass <= 1'b0;
        bypass_model = 1'b0;
        repeat (32) send_random(1'b0, 1'b0);
        drain_words();
        end_test("scrambler bypass");

        start_test();
        apply_reset(1'b0);
        mk0 = markers_seen;
        repeat (96) send_random(1'b0, 1'b0);
        drain_words();
        check_markers(markers_seen - mk0, 3);
        end_test("alignment markers");

        start_test();
        apply_reset(1'b0);
        mk0 = markers_seen;
        repeat (128) send_random(1'b1, 1'b1);
        drain_words();
        check_markers(markers_seen - mk0, 4);
        end_test("random gaps and BIP");

        $display("tests run %0d, words checked %0d, errors %0d",
                 tests_run, words_checked, stim_errors + cmp_errors);
        if ((stim_errors + cmp_errors) == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
logic/pcs_tx_pkg.sv
logic/block_encoder.sv
logic/block_scrambler.sv
logic/lane_distributor.sv
logic/lane_marker_inserter.sv
logic/lane_word_packer.sv
logic/pcs_tx_top.sv
verification/pcs_tx_tb.sv
